// ==== Makefile ====
SIM := obj_dir/ps2_kbd_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): ps2_kbd.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module ps2_kbd_tb -f ps2_kbd.f -o ps2_kbd_sim

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== event_fifo.sv ====
// ============================================================
// event queue: synchronous FIFO, any payload, drops on full
// ============================================================
`timescale 1ns/1ps

module event_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8  // power of two, at least 2
) (
  input  logic     clk_cpu,
  input  logic     arst_n,
  input  payload_t wr_data,
  input  logic     wr_en,
  input  logic     pop,
  output payload_t rd_data,
  output logic     not_empty,
  output logic     overflow
);

  localparam int AW = $clog2(DEPTH);

  payload_t    mem [DEPTH];
  logic [AW:0] wr_ptr;  // extra msb tells full from empty
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_wr;
  logic        do_rd;

  assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign not_empty = wr_ptr != rd_ptr;
  assign do_wr     = wr_en && !full;
  assign do_rd     = pop && not_empty;  // pop on empty is ignored
  assign overflow  = wr_en && full;     // write lost, pulse for the sticky flag

  // show-ahead read of the head entry
  assign rd_data = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (do_wr) mem[wr_ptr[AW-1:0]] <= wr_data;
  end

endmodule

// ==== kbd_axil_regs.sv ====
// ============================================================
// AXI4-Lite register block: STATUS, DATA (pops queue), CONTROL,
// sticky overflow and saturating error counters
// ============================================================
`timescale 1ns/1ps

module kbd_axil_regs (
  input  logic                clk_cpu,
  input  logic                arst_n,
  input  logic [3:0]          awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic [3:0]          wstrb,
  input  logic                wvalid,
  output logic                wready,
  output kbd_pkg::axi_resp_t  bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [3:0]          araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output kbd_pkg::axi_resp_t  rresp,
  output logic                rvalid,
  input  logic                rready,
  input  kbd_pkg::key_event_t head,       // queue head, show-ahead
  input  logic                not_empty,
  input  logic                overflow,   // queue dropped a write
  input  kbd_pkg::rx_err_t    rx_err,
  output logic                pop
);

  import kbd_pkg::*;

  logic        aw_held;  // address taken, waiting for data
  logic        w_held;   // data taken, waiting for address
  logic [3:0]  aw_addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic [3:0]  wr_addr;
  logic [31:0] wr_dat;
  logic [3:0]  wr_stb;
  logic        do_write;
  logic        ctrl_wr;
  logic        clr_ovf;
  logic        clr_cnt;
  logic        ovf_q;
  logic [7:0]  par_cnt;
  logic [7:0]  frm_cnt;
  status_t     status;
  data_reg_t   data_word;
  logic [31:0] rd_word;
  axi_resp_t   rd_resp;

  function automatic logic is_mapped(input logic [3:0] addr);
    return (addr == REG_STATUS) || (addr == REG_DATA) || (addr == REG_CONTROL);
  endfunction

  // one write in flight, ready drops while a response is pending
  assign awready = !aw_held && !bvalid;
  assign wready  = !w_held && !bvalid;
  assign arready = !rvalid;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign ar_hs   = arvalid && arready;

  // take each side from its holding reg or straight off the bus
  assign wr_addr  = aw_held ? aw_addr_q : awaddr;
  assign wr_dat   = w_held ? wdata_q : wdata;
  assign wr_stb   = w_held ? wstrb_q : wstrb;
  assign do_write = (aw_held || aw_hs) && (w_held || w_hs);

  assign ctrl_wr = do_write && (wr_addr == REG_CONTROL) && wr_stb[0];
  assign clr_ovf = ctrl_wr && wr_dat[CTRL_CLR_OVF];
  assign clr_cnt = ctrl_wr && wr_dat[CTRL_CLR_CNT];

  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= RESP_OKAY;
    end else if (do_write) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b1;  // response the cycle after both halves are in
      bresp   <= is_mapped(wr_addr) ? RESP_OKAY : RESP_SLVERR;
    end else begin
      if (aw_hs) aw_held <= 1'b1;
      if (w_hs) w_held <= 1'b1;
      if (bvalid && bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (aw_hs) aw_addr_q <= awaddr;
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  // read word, DATA shows valid=0 and zero payload when empty
  always_comb begin
    status            = '0;
    status.avail      = not_empty;
    status.overflow   = ovf_q;
    status.parity_cnt = par_cnt;
    status.frame_cnt  = frm_cnt;
    data_word         = '0;
    data_word.valid   = not_empty;
    if (not_empty) data_word.ev = head;
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      REG_STATUS:  rd_word = status;
      REG_DATA:    rd_word = data_word;
      REG_CONTROL: rd_word = '0;  // clear bits read back as zero
      default:     rd_resp = RESP_SLVERR;
    endcase
  end

  // pop in the beat the DATA read is accepted
  assign pop = ar_hs && (araddr == REG_DATA) && not_empty;

  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (ar_hs) begin
      rdata <= rd_word;  // held until rready
      rresp <= rd_resp;
    end
  end

  // a new drop wins over a clear in the same cycle
  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      ovf_q   <= 1'b0;
      par_cnt <= '0;
      frm_cnt <= '0;
    end else begin
      if (overflow) ovf_q <= 1'b1;
      else if (clr_ovf) ovf_q <= 1'b0;
      if (clr_cnt) begin
        par_cnt <= '0;
        frm_cnt <= '0;
      end else begin
        if (rx_err.parity_err && par_cnt != 8'hFF) par_cnt <= par_cnt + 1'b1;  // stick at 255
        if (rx_err.frame_err && frm_cnt != 8'hFF) frm_cnt <= frm_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== kbd_pkg.sv ====
// ============================================================
// shared types for the PS/2 keyboard controller: frame, key event,
// receiver errors, register map and layouts, AXI response codes
// ============================================================
package kbd_pkg;

  // one byte accepted off the PS/2 wire
  typedef struct packed {
    logic [7:0] code;
  } ps2_frame_t;

  // decoded key event, 10 bits
  typedef struct packed {
    logic       released;  // 0xF0 came before the code
    logic       extended;  // 0xE0 came before the code
    logic [7:0] code;      // raw set 2 scan code
  } key_event_t;

  // one-cycle strobes from the receiver
  typedef struct packed {
    logic parity_err;  // odd parity failed
    logic frame_err;   // bad start/stop bit or mid-frame timeout
  } rx_err_t;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // register byte offsets
  localparam logic [3:0] REG_STATUS  = 4'h0;
  localparam logic [3:0] REG_DATA    = 4'h4;
  localparam logic [3:0] REG_CONTROL = 4'h8;

  // STATUS, read only
  typedef struct packed {
    logic [7:0] rsvd_hi;     // 31..24
    logic [7:0] frame_cnt;   // 23..16, saturating
    logic [7:0] parity_cnt;  // 15..8, saturating
    logic [5:0] rsvd_lo;     // 7..2
    logic       overflow;    // sticky until CONTROL bit 0
    logic       avail;       // event waiting in the queue
  } status_t;

  // DATA, reading it pops the queue
  typedef struct packed {
    logic        valid;  // 31
    logic [20:0] rsvd;   // 30..10
    key_event_t  ev;     // 9 released, 8 extended, 7..0 code
  } data_reg_t;

  // CONTROL bits, write one to act
  localparam int CTRL_CLR_OVF = 0;
  localparam int CTRL_CLR_CNT = 1;

endpackage

// ==== ps2_kbd.f ====
kbd_pkg.sv
ps2_rx.sv
scancode_decoder.sv
event_fifo.sv
kbd_axil_regs.sv
ps2_kbd.sv
ps2_kbd_properties.sv
ps2_kbd_tb.sv

// ==== ps2_kbd.sv ====
// ============================================================
// PS/2 keyboard controller top: receiver, decoder, event queue
// and AXI4-Lite register block
// ============================================================
`timescale 1ns/1ps

module ps2_kbd #(
  parameter int FIFO_DEPTH     = 8,     // power of two
  parameter int TIMEOUT_CYCLES = 2000,  // max clk_cpu cycles between ps2 clock falls
  parameter int SYNC_STAGES    = 2
) (
  input  logic               clk_cpu,
  input  logic               arst_n,
  input  logic               ps2_clk,
  input  logic               ps2_data,
  input  logic [3:0]         awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [31:0]        wdata,
  input  logic [3:0]         wstrb,
  input  logic               wvalid,
  output logic               wready,
  output kbd_pkg::axi_resp_t bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [3:0]         araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [31:0]        rdata,
  output kbd_pkg::axi_resp_t rresp,
  output logic               rvalid,
  input  logic               rready
);

  import kbd_pkg::*;

  ps2_frame_t frame;
  logic       frame_valid;
  rx_err_t    rx_err;
  key_event_t key_event;
  logic       event_valid;
  key_event_t head;
  logic       not_empty;
  logic       fifo_ovf;
  logic       pop;

  // decode stage
  ps2_rx #(
    .SYNC_STAGES   (SYNC_STAGES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_ps2_rx (
    .clk_cpu    (clk_cpu),
    .arst_n     (arst_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame      (frame),
    .frame_valid(frame_valid),
    .rx_err     (rx_err)
  );

  scancode_decoder i_scancode_decoder (
    .clk_cpu    (clk_cpu),
    .arst_n     (arst_n),
    .frame      (frame),
    .frame_valid(frame_valid),
    .key_event  (key_event),
    .event_valid(event_valid)
  );

  // execute stage
  event_fifo #(
    .payload_t(key_event_t),
    .DEPTH    (FIFO_DEPTH)
  ) i_event_fifo (
    .clk_cpu  (clk_cpu),
    .arst_n   (arst_n),
    .wr_data  (key_event),
    .wr_en    (event_valid),
    .pop      (pop),
    .rd_data  (head),
    .not_empty(not_empty),
    .overflow (fifo_ovf)
  );

  // result stage
  kbd_axil_regs i_kbd_axil_regs (
    .clk_cpu  (clk_cpu),
    .arst_n   (arst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .head     (head),
    .not_empty(not_empty),
    .overflow (fifo_ovf),
    .rx_err   (rx_err),
    .pop      (pop)
  );

endmodule

// ==== ps2_kbd_properties.sv ====
// ============================================================
// assertions on kbd_axil_regs: B/R hold, pop, reset state
// ============================================================
`timescale 1ns/1ps

module ps2_kbd_properties (
  input logic        clk_cpu,
  input logic        arst_n,
  input logic        bvalid,
  input logic        bready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic        pop
);

  // response stays up until the master takes it
  b_hold: assert property (@(posedge clk_cpu) disable iff (!arst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge clk_cpu) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // a pop hands a valid DATA word to the R channel, so an entry was there
  pop_needs_entry: assert property (@(posedge clk_cpu) disable iff (!arst_n)
    pop |=> rvalid && rdata[31])
    else $error("pop without a valid entry returned on the R channel");

  reset_quiet: assert property (@(posedge clk_cpu) !arst_n |-> !bvalid && !rvalid)
    else $error("response valid during reset");

endmodule

bind kbd_axil_regs ps2_kbd_properties i_ps2_kbd_properties (
  .clk_cpu  (clk_cpu),
  .arst_n   (arst_n),
  .bvalid   (bvalid),
  .bready   (bready),
  .rvalid   (rvalid),
  .rready   (rready),
  .rdata    (rdata),
  .pop      (pop)
);

// ==== ps2_kbd_tb.sv ====
// ============================================================
// testbench for the PS/2 keyboard controller: clock, PS/2 frame
// driver, AXI4-Lite tasks, LCG stimulus, event model, checks
// ============================================================
`timescale 1ns/1ps

module ps2_kbd_tb;

  import kbd_pkg::*;

  localparam int FIFO_DEPTH     = 4;     // small queue, overflow comes quickly
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HALF_BIT       = 50;    // ps2 clock half period in clk_cpu cycles
  localparam int FRAME_CYCLES   = 11 * 2 * HALF_BIT;
  localparam int N_RAND         = 10;
  // worst case frames: 3 per random key, 4 parity, 2 bad stop, stall as 3,
  // 2 for the key after errors, 6 overflow, 2 for the key after the empty read
  localparam int MAX_FRAMES     = N_RAND * 3 + 4 + 2 + 3 + 2 + 6 + 2;
  localparam int CYCLE_LIMIT    = MAX_FRAMES * FRAME_CYCLES + 5000;

  logic        clk_cpu;
  logic        arst_n;
  logic        ps2_clk;
  logic        ps2_data;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  axi_resp_t   bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  axi_resp_t   rresp;
  logic        rvalid;
  logic        rready;

  key_event_t  model_q[$];  // expected queue contents, oldest first
  logic [7:0]  model_par;
  logic [7:0]  model_frm;
  logic        model_ovf;
  logic [31:0] lcg_state;
  string       test_name;
  int          n_tests;
  int          n_failed;
  int          n_checks;
  int          n_errors;
  int          err_at_start;

  ps2_kbd #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .SYNC_STAGES   (2)
  ) i_ps2_kbd (
    .clk_cpu(clk_cpu), .arst_n(arst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #10 clk_cpu = ~clk_cpu;  // 20 ns period
  end

  // watchdog, limit scales with the number of frames sent
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_cpu);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
    return lcg_state;
  endfunction

  function automatic logic [7:0] sat_inc(input logic [7:0] c);
    return (c == 8'hFF) ? c : c + 8'd1;
  endfunction

  // full queue drops the new event and sets the sticky flag
  function automatic void model_event(input key_event_t ev);
    if (model_q.size() == FIFO_DEPTH) model_ovf = 1'b1;
    else model_q.push_back(ev);
  endfunction

  task automatic check_event(input string what, input key_event_t exp, input key_event_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s %s: expected rel=%0b ext=%0b code=%02h, actual rel=%0b ext=%0b code=%02h",
               test_name, what, exp.released, exp.extended, exp.code,
               act.released, act.extended, act.code);
    end
  endtask

  task automatic check_count(input string what, input logic [7:0] exp, input logic [7:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s %s: expected %02b, actual %02b", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s %s: expected %0b, actual %0b", test_name, what, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_cpu);
  endtask

  // keyboard puts data up while its clock is high, receiver samples on the fall
  task automatic send_bit(input logic b);
    ps2_data = b;
    wait_cycles(HALF_BIT);
    ps2_clk = 1'b0;
    wait_cycles(HALF_BIT);
    ps2_clk = 1'b1;
  endtask

  task automatic send_frame(input logic [7:0] code, input logic bad_par, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, (~^code) ^ bad_par, code, 1'b0};  // stop, odd parity, data, start
    for (int i = 0; i < 11; i++) send_bit(bits[i]);
    ps2_data = 1'b1;
    wait_cycles(20);  // idle gap between frames
  endtask

  task automatic send_stalled_frame(input logic [7:0] code);
    send_bit(1'b0);
    for (int i = 0; i < 3; i++) send_bit(code[i]);
    ps2_data = 1'b1;
    wait_cycles(TIMEOUT_CYCLES + 200);  // keyboard goes silent mid-frame
  endtask

  // prefixes go out E0 first, then F0, then the key code
  task automatic send_key(input key_event_t ev);
    if (ev.extended) send_frame(8'hE0, 1'b0, 1'b0);
    if (ev.released) send_frame(8'hF0, 1'b0, 1'b0);
    send_frame(ev.code, 1'b0, 1'b0);
    model_event(ev);
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output axi_resp_t resp);
    logic aw_go;
    logic w_go;
    @(negedge clk_cpu);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    wvalid  = 1'b1;
    bready  = 1'b0;  // hold off the response for one cycle
    while (awvalid || wvalid) begin
      aw_go = awvalid && awready;  // ready is settled at the falling edge
      w_go  = wvalid && wready;
      @(negedge clk_cpu);
      if (aw_go) awvalid = 1'b0;
      if (w_go) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge clk_cpu);
    @(negedge clk_cpu);  // bvalid must stay up while bready is low
    check_flag("bvalid held", 1'b1, bvalid);
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk_cpu);  // B handshake on the rising edge in between
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output axi_resp_t resp);
    @(negedge clk_cpu);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;  // stall the R channel for one cycle
    while (!arready) @(negedge clk_cpu);
    @(negedge clk_cpu);  // address taken at the rising edge
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_cpu);
    @(negedge clk_cpu);  // data must hold while rready is low
    check_flag("rvalid held", 1'b1, rvalid);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk_cpu);  // R handshake on the rising edge in between
    rready = 1'b0;
  endtask

  task automatic read_status(output status_t st);
    logic [31:0] d;
    axi_resp_t   rsp;
    axi_read(REG_STATUS, d, rsp);
    st = status_t'(d);
  endtask

  // poll STATUS bit 0, then pop one event and compare with the model
  task automatic read_event(input string what);
    status_t     st;
    logic [31:0] d;
    axi_resp_t   rsp;
    key_event_t  exp;
    st = '0;
    for (int i = 0; i < 20 && !st.avail; i++) read_status(st);
    if (!st.avail) begin
      n_errors++;
      $display("ERROR %s %s: STATUS never reported an event", test_name, what);
    end else if (model_q.size() == 0) begin
      n_errors++;
      $display("ERROR %s %s: DUT reported an event the model does not expect", test_name, what);
    end else begin
      exp = model_q.pop_front();
      axi_read(REG_DATA, d, rsp);
      check_flag({what, " valid"}, 1'b1, d[31]);
      check_event(what, exp, key_event_t'(d[9:0]));
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = n_errors;
    n_tests++;
  endtask

  task automatic finish_test();
    if (n_errors == err_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", test_name, n_errors - err_at_start);
    end
  endtask

  initial begin : stimulus
    status_t     st;
    logic [31:0] d;
    logic [31:0] r;
    axi_resp_t   rsp;
    key_event_t  ev;
    int          n_par;
    arst_n    = 1'b0;
    ps2_clk   = 1'b1;  // both lines idle high
    ps2_data  = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    lcg_state = 32'haff04095;
    model_par = '0;
    model_frm = '0;
    model_ovf = 1'b0;
    n_tests   = 0;
    n_failed  = 0;
    n_checks  = 0;
    n_errors  = 0;
    wait_cycles(10);
    arst_n = 1'b1;
    wait_cycles(5);

    // make, break and extended codes read back one by one
    start_test("random_keys");
    for (int i = 0; i < N_RAND; i++) begin
      r  = next_random();
      ev = '{released: r[9], extended: r[8], code: {1'b0, r[6:0]}};
      send_key(ev);
      read_event($sformatf("key %0d", i));
    end
    finish_test();

    start_test("parity_err");
    n_par = 2 + int'(next_random() % 32'd3);
    for (int i = 0; i < n_par; i++) begin
      r = next_random();
      send_frame({1'b0, r[6:0]}, 1'b1, 1'b0);
      model_par = sat_inc(model_par);
    end
    read_status(st);
    check_flag("no event", 1'b0, st.avail);
    check_count("parity count", model_par, st.parity_cnt);
    check_count("frame count", model_frm, st.frame_cnt);
    finish_test();

    // two bad stop bits and one stalled frame
    start_test("frame_err");
    for (int i = 0; i < 2; i++) begin
      r = next_random();
      send_frame({1'b0, r[6:0]}, 1'b0, 1'b1);
      model_frm = sat_inc(model_frm);
    end
    r = next_random();
    send_stalled_frame(r[31:24]);
    model_frm = sat_inc(model_frm);
    read_status(st);
    check_flag("no event", 1'b0, st.avail);
    check_count("frame count", model_frm, st.frame_cnt);
    check_count("parity count", model_par, st.parity_cnt);
    r  = next_random();
    ev = '{released: 1'b0, extended: r[8], code: {1'b0, r[6:0]}};
    send_key(ev);
    read_event("key after errors");
    finish_test();

    start_test("overflow");
    for (int i = 0; i < 6; i++) begin
      r = next_random();
      send_key('{released: 1'b0, extended: 1'b0, code: {1'b0, r[6:0]}});
    end
    read_status(st);
    check_flag("overflow set", model_ovf, st.overflow);
    for (int i = 0; i < FIFO_DEPTH; i++) read_event($sformatf("kept %0d", i));
    axi_write(REG_CONTROL, 32'h1, rsp);  // clear overflow only
    check_resp("clear overflow", RESP_OKAY, rsp);
    model_ovf = 1'b0;
    read_status(st);
    check_flag("overflow cleared", model_ovf, st.overflow);
    check_count("parity count kept", model_par, st.parity_cnt);
    check_count("frame count kept", model_frm, st.frame_cnt);
    axi_write(REG_CONTROL, 32'h2, rsp);  // clear both counters
    check_resp("clear counters", RESP_OKAY, rsp);
    model_par = '0;
    model_frm = '0;
    read_status(st);
    check_count("parity count cleared", model_par, st.parity_cnt);
    check_count("frame count cleared", model_frm, st.frame_cnt);
    finish_test();

    start_test("empty_unmapped");
    axi_read(REG_DATA, d, rsp);
    check_flag("empty data valid", 1'b0, d[31]);
    check_resp("empty data read", RESP_OKAY, rsp);
    r  = next_random();
    ev = '{released: r[9], extended: 1'b0, code: {1'b0, r[6:0]}};
    send_key(ev);
    read_event("key after empty read");  // pointers untouched by the empty read
    axi_read(4'hC, d, rsp);
    check_resp("unmapped read", RESP_SLVERR, rsp);
    axi_write(4'hC, 32'h3, rsp);
    check_resp("unmapped write", RESP_SLVERR, rsp);
    axi_write(REG_STATUS, 32'h0, rsp);
    check_resp("status write", RESP_OKAY, rsp);
    axi_read(REG_STATUS, d, rsp);
    check_resp("status read", RESP_OKAY, rsp);
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== ps2_rx.sv ====
// ============================================================
// PS/2 receiver: line sync, clock fall detect, frame FSM with
// parity/stop checks and a mid-frame timeout
// ============================================================
`timescale 1ns/1ps

module ps2_rx #(
  parameter int SYNC_STAGES    = 2,
  parameter int TIMEOUT_CYCLES = 2000
) (
  input  logic                clk_cpu,
  input  logic                arst_n,
  input  logic                ps2_clk,   // async from keyboard
  input  logic                ps2_data,  // async from keyboard
  output kbd_pkg::ps2_frame_t frame,
  output logic                frame_valid,
  output kbd_pkg::rx_err_t    rx_err
);

  localparam int TMO_W = $clog2(TIMEOUT_CYCLES);

  typedef enum logic [1:0] {
    S_IDLE,    // waiting for the start bit
    S_DATA,    // eight data bits, lsb first
    S_PARITY,
    S_STOP
  } state_t;

  logic [SYNC_STAGES-1:0] clk_sync;
  logic [SYNC_STAGES-1:0] data_sync;
  logic                   clk_s;
  logic                   data_s;
  logic                   clk_prev;
  logic                   fall;      // synchronized falling edge of ps2_clk
  state_t                 state;
  logic [2:0]             bit_cnt;
  logic [7:0]             shift_q;
  logic                   par_ok;
  logic [TMO_W-1:0]       tmo_cnt;
  logic                   tmo_hit;

  // both lines idle high, so the chains reset to ones
  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= '1;
      data_sync <= '1;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= (clk_sync << 1) | SYNC_STAGES'(ps2_clk);
      data_sync <= (data_sync << 1) | SYNC_STAGES'(ps2_data);
      clk_prev  <= clk_s;
    end
  end

  assign clk_s  = clk_sync[SYNC_STAGES-1];
  assign data_s = data_sync[SYNC_STAGES-1];
  assign fall   = clk_prev & ~clk_s;

  // keyboard went quiet in the middle of a frame
  assign tmo_hit = (state != S_IDLE) && !fall && (tmo_cnt == TMO_W'(TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      state       <= S_IDLE;
      bit_cnt     <= '0;
      par_ok      <= 1'b0;
      tmo_cnt     <= '0;
      frame_valid <= 1'b0;
      rx_err      <= '0;
    end else begin
      frame_valid <= 1'b0;  // strobes, low by default
      rx_err      <= '0;
      if (fall || state == S_IDLE) tmo_cnt <= '0;  // measure gap between falls
      else tmo_cnt <= tmo_cnt + 1'b1;

      if (tmo_hit) begin
        state            <= S_IDLE;  // abort frame
        rx_err.frame_err <= 1'b1;
      end else if (fall) begin
        case (state)
          S_IDLE: begin
            if (!data_s) begin
              state   <= S_DATA;
              bit_cnt <= '0;
            end else begin
              rx_err.frame_err <= 1'b1;  // start bit not 0
            end
          end
          S_DATA: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= S_PARITY;
          end
          S_PARITY: begin
            par_ok <= ^{shift_q, data_s};  // odd count of ones is good
            state  <= S_STOP;
          end
          S_STOP: begin
            state <= S_IDLE;
            // a bad stop bit outranks bad parity
            if (!data_s) rx_err.frame_err <= 1'b1;
            else if (!par_ok) rx_err.parity_err <= 1'b1;
            else frame_valid <= 1'b1;
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // data shift register, lsb arrives first
  always_ff @(posedge clk_cpu) begin
    if (fall && state == S_DATA) shift_q <= {data_s, shift_q[7:1]};
  end

  assign frame.code = shift_q;  // stable until the next frame's data bits

endmodule

// ==== scancode_decoder.sv ====
// ============================================================
// scan code decoder: folds E0/F0 prefixes into key event flags
// ============================================================
`timescale 1ns/1ps

module scancode_decoder (
  input  logic                clk_cpu,
  input  logic                arst_n,
  input  kbd_pkg::ps2_frame_t frame,
  input  logic                frame_valid,
  output kbd_pkg::key_event_t key_event,
  output logic                event_valid
);

  localparam logic [7:0] CODE_EXT = 8'hE0;  // extended key prefix
  localparam logic [7:0] CODE_BRK = 8'hF0;  // key release prefix

  logic pend_ext;  // E0 seen, waiting for the key code
  logic pend_brk;  // F0 seen, waiting for the key code
  logic is_ext;
  logic is_brk;
  logic is_key;

  assign is_ext = frame.code == CODE_EXT;
  assign is_brk = frame.code == CODE_BRK;
  // anything else ends a sequence, E1 (pause) included
  assign is_key = frame_valid && !is_ext && !is_brk;

  // prefixes may stack as E0 F0 xx for an extended release
  always_ff @(posedge clk_cpu or negedge arst_n) begin
    if (!arst_n) begin
      pend_ext    <= 1'b0;
      pend_brk    <= 1'b0;
      event_valid <= 1'b0;
    end else begin
      event_valid <= is_key;  // one cycle after frame_valid
      if (frame_valid) begin
        if (is_ext) begin
          pend_ext <= 1'b1;
        end else if (is_brk) begin
          pend_brk <= 1'b1;
        end else begin
          pend_ext <= 1'b0;  // consumed by this event
          pend_brk <= 1'b0;
        end
      end
    end
  end

  // event payload, valid only alongside event_valid
  always_ff @(posedge clk_cpu) begin
    if (is_key) begin
      key_event <= '{released: pend_brk, extended: pend_ext, code: frame.code};
    end
  end

endmodule
